//--- src/decode_pkg.sv
package decode_pkg;

    localparam int LANES      = 2;
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // opcode patterns, matched against inst[31:15]
    localparam logic [16:0] OP_ADD_W   = 17'b00000000000100000;
    localparam logic [16:0] OP_SUB_W   = 17'b00000000000100010;
    localparam logic [16:0] OP_SLT     = 17'b00000000000100100;
    localparam logic [16:0] OP_AND     = 17'b00000000000101001;
    localparam logic [16:0] OP_OR      = 17'b00000000000101010;
    localparam logic [16:0] OP_XOR     = 17'b00000000000101011;
    localparam logic [16:0] OP_MUL_W   = 17'b00000000000111000;
    localparam logic [16:0] OP_DIV_W   = 17'b00000000001000000;
    localparam logic [16:0] OP_ADDI_W  = 17'b0000001010???????;
    localparam logic [16:0] OP_ANDI    = 17'b0000001101???????;
    localparam logic [16:0] OP_ORI     = 17'b0000001110???????;
    localparam logic [16:0] OP_LD_W    = 17'b0010100010???????;
    localparam logic [16:0] OP_ST_W    = 17'b0010100110???????;
    localparam logic [16:0] OP_LU12I_W = 17'b0001010??????????;
    localparam logic [16:0] OP_JIRL    = 17'b010011???????????;
    localparam logic [16:0] OP_B       = 17'b010100???????????;
    localparam logic [16:0] OP_BL      = 17'b010101???????????;
    localparam logic [16:0] OP_BEQ     = 17'b010110???????????;
    localparam logic [16:0] OP_BNE     = 17'b010111???????????;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_rr_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] imm16;   // si12/ui12 sit in the low bits
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_imm_t;

    typedef union packed {
        inst_rr_t  rr;
        inst_imm_t imm;
    } inst_word_u;

    typedef enum logic [2:0] {REG_NONE, REG_RD, REG_RJ, REG_RK, REG_IMM, REG_ZERO} reg_src_e;
    typedef enum logic [1:0] {DST_NONE, DST_RD, DST_R1} reg_dst_e;
    typedef enum logic [1:0] {IMM_NONE, IMM_SI12, IMM_UI12, IMM_SI20_SL12} imm_kind_e;
    typedef enum logic [1:0] {ADDR_NONE, ADDR_OFF16_SL2, ADDR_OFF26_SL2} addr_kind_e;
    typedef enum logic [1:0] {UNIT_ALU, UNIT_MDU, UNIT_LSU, UNIT_BRANCH} unit_e;

    typedef struct packed {
        inst_word_u inst;
        reg_src_e   src0;
        reg_src_e   src1;
        reg_dst_e   dst;
        imm_kind_e  imm_kind;
        addr_kind_e addr_kind;
        unit_e      unit;
        logic       store;
    } decode_info_t;

    typedef struct packed {
        logic [LANES-1:0]        mask;
        logic [LANES-1:0][31:0]  pc;
        inst_word_u [LANES-1:0]  insts;
    } f_d_pkg_t;

    typedef struct packed {
        logic [LANES-1:0]          r_valid;
        logic [LANES-1:0][31:0]    pc;
        logic [2*LANES-1:0][4:0]   r_arfid;   // two read ports per lane
        logic [LANES-1:0][4:0]     w_arfid;
        logic [2*LANES-1:0]        reg_need;
        logic [2*LANES-1:0]        use_imm;
        logic [LANES-1:0]          w_reg;
        logic [LANES-1:0]          w_mem;
        unit_e [LANES-1:0]         unit;
        logic [LANES-1:0][31:0]    data_imm;
        logic [LANES-1:0][31:0]    addr_imm;
    } d_r_pkg_t;

endpackage

//--- src/basic_decoder.sv
`timescale 1ns/1ps

module basic_decoder (
    input  decode_pkg::inst_word_u   ins_i,
    output decode_pkg::decode_info_t decode_info_o
);
    import decode_pkg::*;

    always_comb begin
        // nop info unless a pattern below matches
        decode_info_o.inst      = ins_i;
        decode_info_o.src0      = REG_NONE;
        decode_info_o.src1      = REG_NONE;
        decode_info_o.dst       = DST_NONE;
        decode_info_o.imm_kind  = IMM_NONE;
        decode_info_o.addr_kind = ADDR_NONE;
        decode_info_o.unit      = UNIT_ALU;
        decode_info_o.store     = 1'b0;

        unique casez (ins_i.rr.opcode)
            OP_ADD_W, OP_SUB_W, OP_SLT, OP_AND, OP_OR, OP_XOR: begin
                decode_info_o.src0 = REG_RJ;
                decode_info_o.src1 = REG_RK;
                decode_info_o.dst  = DST_RD;
            end
            OP_MUL_W, OP_DIV_W: begin
                decode_info_o.src0 = REG_RJ;
                decode_info_o.src1 = REG_RK;
                decode_info_o.dst  = DST_RD;
                decode_info_o.unit = UNIT_MDU;
            end
            OP_ADDI_W: begin
                decode_info_o.src0     = REG_RJ;
                decode_info_o.src1     = REG_IMM;
                decode_info_o.dst      = DST_RD;
                decode_info_o.imm_kind = IMM_SI12;
            end
            OP_ANDI, OP_ORI: begin
                decode_info_o.src0     = REG_RJ;
                decode_info_o.src1     = REG_IMM;
                decode_info_o.dst      = DST_RD;
                decode_info_o.imm_kind = IMM_UI12;   // logical ops zero-extend
            end
            OP_LU12I_W: begin
                decode_info_o.src0     = REG_ZERO;
                decode_info_o.src1     = REG_IMM;
                decode_info_o.dst      = DST_RD;
                decode_info_o.imm_kind = IMM_SI20_SL12;
            end
            OP_LD_W: begin
                decode_info_o.src0     = REG_RJ;
                decode_info_o.src1     = REG_IMM;
                decode_info_o.dst      = DST_RD;
                decode_info_o.imm_kind = IMM_SI12;
                decode_info_o.unit     = UNIT_LSU;
            end
            OP_ST_W: begin
                decode_info_o.src0     = REG_RJ;
                decode_info_o.src1     = REG_RD;   // store data comes from rd
                decode_info_o.imm_kind = IMM_SI12;
                decode_info_o.unit     = UNIT_LSU;
                decode_info_o.store    = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                decode_info_o.src0      = REG_RJ;
                decode_info_o.src1      = REG_RD;
                decode_info_o.addr_kind = ADDR_OFF16_SL2;
                decode_info_o.unit      = UNIT_BRANCH;
            end
            OP_JIRL: begin
                decode_info_o.src0      = REG_RJ;
                decode_info_o.dst       = DST_RD;   // link register
                decode_info_o.addr_kind = ADDR_OFF16_SL2;
                decode_info_o.unit      = UNIT_BRANCH;
            end
            OP_B: begin
                decode_info_o.addr_kind = ADDR_OFF26_SL2;
                decode_info_o.unit      = UNIT_BRANCH;
            end
            OP_BL: begin
                decode_info_o.dst       = DST_R1;
                decode_info_o.addr_kind = ADDR_OFF26_SL2;
                decode_info_o.unit      = UNIT_BRANCH;
            end
            default: ;
        endcase
    end

endmodule

//--- src/imm_extract.sv
`timescale 1ns/1ps

module imm_extract (
    input  decode_pkg::inst_word_u ins_i,
    input  decode_pkg::imm_kind_e  imm_kind_i,
    input  decode_pkg::addr_kind_e addr_kind_i,
    output logic [31:0]            data_imm_o,
    output logic [31:0]            addr_imm_o
);
    import decode_pkg::*;

    logic [15:0] imm16;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [25:0] offs26;

    assign imm16  = ins_i.imm.imm16;
    assign imm12  = imm16[11:0];                          // inst[21:10]
    assign imm20  = {imm16[14:0], ins_i.imm.rj};          // inst[24:5]
    // offs[25:16] lives in inst[9:0]
    assign offs26 = {ins_i.imm.rj, ins_i.imm.rd, imm16};

    always_comb begin
        case (imm_kind_i)
            IMM_SI12:      data_imm_o = {{20{imm12[11]}}, imm12};
            IMM_UI12:      data_imm_o = {20'b0, imm12};
            IMM_SI20_SL12: data_imm_o = {imm20, 12'b0};
            default:       data_imm_o = '0;
        endcase
    end

    always_comb begin
        case (addr_kind_i)
            ADDR_OFF16_SL2: addr_imm_o = {{14{imm16[15]}}, imm16, 2'b00};
            ADDR_OFF26_SL2: addr_imm_o = {{4{offs26[25]}}, offs26, 2'b00};
            default:        addr_imm_o = '0;
        endcase
    end

endmodule

//--- src/decoder.sv
`timescale 1ns/1ps

// combinational; the stage register is the queue in front
module decoder (
    input  logic                 receiver_valid_i,
    output logic                 receiver_ready_o,
    input  decode_pkg::f_d_pkg_t receiver_pkg_i,
    output logic                 sender_valid_o,
    input  logic                 sender_ready_i,
    output decode_pkg::d_r_pkg_t sender_pkg_o
);
    import decode_pkg::*;

    decode_info_t [LANES-1:0] infos;
    logic [LANES-1:0][31:0]   data_imm;
    logic [LANES-1:0][31:0]   addr_imm;

    // index 0 whenever the source is not a register field
    function automatic logic [4:0] src_index(input reg_src_e src, input inst_word_u ins);
        case (src)
            REG_RD:  return ins.rr.rd;
            REG_RJ:  return ins.rr.rj;
            REG_RK:  return ins.rr.rk;
            default: return 5'd0;
        endcase
    endfunction

    function automatic logic needs_reg(input reg_src_e src);
        return src == REG_RD || src == REG_RJ || src == REG_RK;
    endfunction

    assign sender_valid_o   = receiver_valid_i;   // only data changes here
    assign receiver_ready_o = sender_ready_i;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        basic_decoder u_basic_decoder (
            .ins_i         (receiver_pkg_i.insts[i]),
            .decode_info_o (infos[i])
        );

        imm_extract u_imm_extract (
            .ins_i       (infos[i].inst),
            .imm_kind_i  (infos[i].imm_kind),
            .addr_kind_i (infos[i].addr_kind),
            .data_imm_o  (data_imm[i]),
            .addr_imm_o  (addr_imm[i])
        );

        // the link to r1 must come from a bl word, not some other encoding
        always_comb begin : chk_r1_link
            a_r1_only_bl: assert final (infos[i].dst != DST_R1 ||
                                        infos[i].inst.rr.opcode ==? OP_BL)
                else $error("lane %0d writes r1 from a non-bl word", i);
        end
    end

    always_comb begin
        sender_pkg_o.r_valid = receiver_pkg_i.mask;
        sender_pkg_o.pc      = receiver_pkg_i.pc;
        for (int i = 0; i < LANES; i++) begin
            sender_pkg_o.r_arfid[2*i]    = src_index(infos[i].src0, infos[i].inst);
            sender_pkg_o.r_arfid[2*i+1]  = src_index(infos[i].src1, infos[i].inst);
            sender_pkg_o.reg_need[2*i]   = needs_reg(infos[i].src0);
            sender_pkg_o.reg_need[2*i+1] = needs_reg(infos[i].src1);
            sender_pkg_o.use_imm[2*i]    = infos[i].src0 == REG_IMM;
            sender_pkg_o.use_imm[2*i+1]  = infos[i].src1 == REG_IMM;

            case (infos[i].dst)
                DST_RD:  sender_pkg_o.w_arfid[i] = infos[i].inst.rr.rd;
                DST_R1:  sender_pkg_o.w_arfid[i] = 5'd1;   // bl only
                default: sender_pkg_o.w_arfid[i] = 5'd0;
            endcase
            sender_pkg_o.w_reg[i]    = infos[i].dst != DST_NONE;
            sender_pkg_o.w_mem[i]    = infos[i].store;
            sender_pkg_o.unit[i]     = infos[i].unit;
            sender_pkg_o.data_imm[i] = data_imm[i];
            sender_pkg_o.addr_imm[i] = addr_imm[i];
        end
    end

endmodule

//--- src/decode_fifo.sv
`timescale 1ns/1ps

module decode_fifo (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 push_valid_i,
    output logic                 push_ready_o,
    input  decode_pkg::f_d_pkg_t push_pkg_i,
    output logic                 pop_valid_o,
    input  logic                 pop_ready_i,
    output decode_pkg::f_d_pkg_t pop_pkg_o
);
    import decode_pkg::*;

    f_d_pkg_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  full;
    logic                  push_fire;
    logic                  pop_fire;

    function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full         = count == FIFO_CNT_W'(FIFO_DEPTH);
    assign pop_valid_o  = count != '0;
    assign push_ready_o = !full || pop_ready_i;   // pop frees a slot this cycle
    assign pop_pkg_o    = mem[rd_ptr];
    assign push_fire    = push_valid_i && push_ready_o;
    assign pop_fire     = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_pkg_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= next_ptr(wr_ptr);
            if (pop_fire) rd_ptr <= next_ptr(rd_ptr);
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset_i)
        count <= FIFO_CNT_W'(FIFO_DEPTH));

    // stalled head must not change under the consumer
    a_head_stable: assert property (@(posedge clk) disable iff (reset_i)
        pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_pkg_o));

endmodule

//--- src/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 f_valid_i,
    output logic                 f_ready_o,
    input  decode_pkg::f_d_pkg_t f_pkg_i,
    output logic                 d_valid_o,
    input  logic                 d_ready_i,
    output decode_pkg::d_r_pkg_t d_pkg_o
);
    import decode_pkg::*;

    logic     q_valid;
    logic     q_ready;
    f_d_pkg_t q_pkg;   // buffered fetch packet

    decode_fifo u_decode_fifo (
        .clk          (clk),
        .reset_i      (reset_i),
        .push_valid_i (f_valid_i),
        .push_ready_o (f_ready_o),
        .push_pkg_i   (f_pkg_i),
        .pop_valid_o  (q_valid),
        .pop_ready_i  (q_ready),
        .pop_pkg_o    (q_pkg)
    );

    decoder u_decoder (
        .receiver_valid_i (q_valid),
        .receiver_ready_o (q_ready),
        .receiver_pkg_i   (q_pkg),
        .sender_valid_o   (d_valid_o),
        .sender_ready_i   (d_ready_i),
        .sender_pkg_o     (d_pkg_o)
    );

endmodule

//--- tb/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_MUL, K_DIV,
    K_ADDI, K_ANDI, K_ORI, K_LU12I, K_LD, K_ST,
    K_BEQ, K_BNE, K_B, K_BL, K_JIRL, K_ILLEGAL
} op_kind_e;

typedef enum logic [2:0] {S_NONE, S_RD, S_RJ, S_RK, S_IMM, S_ZERO} src_sel_e;
typedef enum logic [1:0] {D_NONE, D_RD, D_R1} dst_sel_e;
typedef enum logic [2:0] {X_NONE, X_SI12, X_UI12, X_SI20, X_OFF16, X_OFF26} ext_sel_e;

// expected behavior of one instruction class
typedef struct packed {
    src_sel_e s0;
    src_sel_e s1;
    dst_sel_e dst;
    ext_sel_e ext;
    unit_e    unit;
    logic     store;
} profile_t;

// r supplies the register fields and immediate bits
function automatic logic [31:0] encode_inst(input op_kind_e k, input logic [31:0] r);
    case (k)
        K_ADD:   return {17'h00020, r[14:0]};
        K_SUB:   return {17'h00022, r[14:0]};
        K_SLT:   return {17'h00024, r[14:0]};
        K_AND:   return {17'h00029, r[14:0]};
        K_OR:    return {17'h0002a, r[14:0]};
        K_XOR:   return {17'h0002b, r[14:0]};
        K_MUL:   return {17'h00038, r[14:0]};
        K_DIV:   return {17'h00040, r[14:0]};
        K_ADDI:  return {10'b0000001010, r[21:0]};
        K_ANDI:  return {10'b0000001101, r[21:0]};
        K_ORI:   return {10'b0000001110, r[21:0]};
        K_LD:    return {10'b0010100010, r[21:0]};
        K_ST:    return {10'b0010100110, r[21:0]};
        K_LU12I: return {7'b0001010, r[24:0]};
        K_JIRL:  return {6'b010011, r[25:0]};
        K_B:     return {6'b010100, r[25:0]};
        K_BL:    return {6'b010101, r[25:0]};
        K_BEQ:   return {6'b010110, r[25:0]};
        K_BNE:   return {6'b010111, r[25:0]};
        // top bits 1x or 011 lie outside the subset
        default: return r[31] ? {1'b1, r[30:0]} : {3'b011, r[28:0]};
    endcase
endfunction

function automatic profile_t kind_profile(input op_kind_e k);
    case (k)
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT:
            return '{S_RJ, S_RK, D_RD, X_NONE, UNIT_ALU, 1'b0};
        K_MUL, K_DIV:  return '{S_RJ, S_RK, D_RD, X_NONE, UNIT_MDU, 1'b0};
        K_ADDI:        return '{S_RJ, S_IMM, D_RD, X_SI12, UNIT_ALU, 1'b0};
        K_ANDI, K_ORI: return '{S_RJ, S_IMM, D_RD, X_UI12, UNIT_ALU, 1'b0};
        K_LU12I:       return '{S_ZERO, S_IMM, D_RD, X_SI20, UNIT_ALU, 1'b0};
        K_LD:          return '{S_RJ, S_IMM, D_RD, X_SI12, UNIT_LSU, 1'b0};
        K_ST:          return '{S_RJ, S_RD, D_NONE, X_SI12, UNIT_LSU, 1'b1};
        K_BEQ, K_BNE:  return '{S_RJ, S_RD, D_NONE, X_OFF16, UNIT_BRANCH, 1'b0};
        K_JIRL:        return '{S_RJ, S_NONE, D_RD, X_OFF16, UNIT_BRANCH, 1'b0};
        K_B:           return '{S_NONE, S_NONE, D_NONE, X_OFF26, UNIT_BRANCH, 1'b0};
        K_BL:          return '{S_NONE, S_NONE, D_R1, X_OFF26, UNIT_BRANCH, 1'b0};
        default:       return '{S_NONE, S_NONE, D_NONE, X_NONE, UNIT_ALU, 1'b0};
    endcase
endfunction

function automatic logic [4:0] src_reg(input src_sel_e s, input logic [31:0] w);
    case (s)
        S_RD:    return w[4:0];
        S_RJ:    return w[9:5];
        S_RK:    return w[14:10];
        default: return 5'd0;   // imm, zero and none
    endcase
endfunction

function automatic d_r_pkg_t expect_lane(input d_r_pkg_t p_in, input int lane,
                                         input op_kind_e k, input logic [31:0] w);
    d_r_pkg_t    p;
    profile_t    f;
    logic [25:0] off26;
    p     = p_in;
    f     = kind_profile(k);
    off26 = {w[9:0], w[25:10]};
    p.r_arfid[2*lane]    = src_reg(f.s0, w);
    p.r_arfid[2*lane+1]  = src_reg(f.s1, w);
    p.reg_need[2*lane]   = f.s0 inside {S_RD, S_RJ, S_RK};
    p.reg_need[2*lane+1] = f.s1 inside {S_RD, S_RJ, S_RK};
    p.use_imm[2*lane]    = f.s0 == S_IMM;
    p.use_imm[2*lane+1]  = f.s1 == S_IMM;
    p.w_reg[lane]        = f.dst != D_NONE;
    p.w_arfid[lane]      = (f.dst == D_RD) ? w[4:0] : ((f.dst == D_R1) ? 5'd1 : 5'd0);
    p.w_mem[lane]        = f.store;
    p.unit[lane]         = f.unit;
    p.data_imm[lane]     = '0;
    p.addr_imm[lane]     = '0;
    case (f.ext)
        X_SI12:  p.data_imm[lane] = {{20{w[21]}}, w[21:10]};
        X_UI12:  p.data_imm[lane] = {20'd0, w[21:10]};
        X_SI20:  p.data_imm[lane] = {w[24:5], 12'd0};
        X_OFF16: p.addr_imm[lane] = {{14{w[25]}}, w[25:10], 2'b00};
        X_OFF26: p.addr_imm[lane] = {{4{off26[25]}}, off26, 2'b00};
        default: ;
    endcase
    return p;
endfunction

function automatic d_r_pkg_t expect_pkt(input f_d_pkg_t pkt, input op_kind_e k0,
                                        input op_kind_e k1);
    d_r_pkg_t p;
    p         = '0;
    p.r_valid = pkt.mask;   // lanes decode even when masked off
    p.pc      = pkt.pc;
    p         = expect_lane(p, 0, k0, pkt.insts[0]);
    p         = expect_lane(p, 1, k1, pkt.insts[1]);
    return p;
endfunction

`endif

//--- tb/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top;
    import decode_pkg::*;

    `include "decode_ref_model.svh"

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 5;
    localparam int NUM_PER_TEST    = 200;
    localparam int NUM_PKTS        = NUM_TESTS * NUM_PER_TEST;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_PKTS * 20;
    localparam int DRAIN_CYCLES    = 100;

    logic     clk;
    logic     reset_i;
    logic     f_valid_i;
    logic     f_ready_o;
    f_d_pkg_t f_pkg_i;
    logic     d_valid_o;
    logic     d_ready_i;
    d_r_pkg_t d_pkg_o;

    int       seed = 86457;
    int       errors = 0;       // main process checks
    int       mon_errors = 0;   // output monitor checks
    int       sent = 0;
    int       received = 0;
    logic     ready_on = 1'b0;
    logic     heavy_stall = 1'b0;
    logic     stalled = 1'b0;
    d_r_pkg_t held_pkg;
    d_r_pkg_t exp_q[$];
    string    name_q[$];
    string    test_names [NUM_TESTS] = '{"reg_reg", "immediate", "control",
                                         "mask_illegal", "order"};

    decode_top u_dut (
        .clk       (clk),
        .reset_i   (reset_i),
        .f_valid_i (f_valid_i),
        .f_ready_o (f_ready_o),
        .f_pkg_i   (f_pkg_i),
        .d_valid_o (d_valid_o),
        .d_ready_i (d_ready_i),
        .d_pkg_o   (d_pkg_o)
    );

    function automatic int show_mismatch(input string test, input string field,
                                         input logic [63:0] exp, input logic [63:0] act);
        $display("error %s %s expected %h actual %h", test, field, exp, act);
        return 1;
    endfunction

    function automatic int compare_pkt(input string test, input d_r_pkg_t exp,
                                       input d_r_pkg_t act);
        int n;
        n = 0;
        if (act.r_valid !== exp.r_valid)
            n += show_mismatch(test, "r_valid", 64'(exp.r_valid), 64'(act.r_valid));
        if (act.pc !== exp.pc)
            n += show_mismatch(test, "pc", exp.pc, act.pc);
        if (act.r_arfid !== exp.r_arfid)
            n += show_mismatch(test, "r_arfid", 64'(exp.r_arfid), 64'(act.r_arfid));
        if (act.w_arfid !== exp.w_arfid)
            n += show_mismatch(test, "w_arfid", 64'(exp.w_arfid), 64'(act.w_arfid));
        if (act.reg_need !== exp.reg_need)
            n += show_mismatch(test, "reg_need", 64'(exp.reg_need), 64'(act.reg_need));
        if (act.use_imm !== exp.use_imm)
            n += show_mismatch(test, "use_imm", 64'(exp.use_imm), 64'(act.use_imm));
        if (act.w_reg !== exp.w_reg)
            n += show_mismatch(test, "w_reg", 64'(exp.w_reg), 64'(act.w_reg));
        if (act.w_mem !== exp.w_mem)
            n += show_mismatch(test, "w_mem", 64'(exp.w_mem), 64'(act.w_mem));
        if (act.unit !== exp.unit)
            n += show_mismatch(test, "unit", 64'(exp.unit), 64'(act.unit));
        if (act.data_imm !== exp.data_imm)
            n += show_mismatch(test, "data_imm", exp.data_imm, act.data_imm);
        if (act.addr_imm !== exp.addr_imm)
            n += show_mismatch(test, "addr_imm", exp.addr_imm, act.addr_imm);
        return n;
    endfunction

    function automatic int check_idle(input string test);
        int n;
        n = 0;
        if (d_valid_o !== 1'b0)
            n += show_mismatch(test, "d_valid_o", 64'd0, 64'(d_valid_o));
        if (f_ready_o !== 1'b1)
            n += show_mismatch(test, "f_ready_o", 64'd1, 64'(f_ready_o));
        return n;
    endfunction

    // instruction class mix for each test
    function automatic op_kind_e pick_kind(input int test, input logic [31:0] r);
        case (test)
            0:       return op_kind_e'(r % 32'd8);
            1:       return op_kind_e'(32'd8 + r % 32'd6);
            2:       return op_kind_e'(32'd14 + r % 32'd5);
            3:       return r[31] ? K_ILLEGAL : op_kind_e'(r % 32'd20);
            default: return op_kind_e'(r % 32'd20);
        endcase
    endfunction

    // valid holds until the queue takes the packet
    task automatic send_pkt(input f_d_pkg_t pkt);
        f_valid_i = 1'b1;
        f_pkg_i   = pkt;
        @(posedge clk);
        while (!f_ready_o) @(posedge clk);
        sent++;
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : drive_ready
        logic [31:0] r;
        logic        next_ready;
        d_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            r          = $random(seed);   // drawn at the edge, stimulus draws come 1 ns later
            next_ready = ready_on && (heavy_stall ? r[0] : (r[1:0] != 2'b00));
            #1;
            d_ready_i  = next_ready;
        end
    end

    initial begin : monitor
        d_r_pkg_t exp;
        string    name;
        forever begin
            @(posedge clk);
            if (!reset_i) begin
                if (stalled && !d_valid_o) begin
                    mon_errors++;
                    $display("d_valid_o dropped while the output was stalled");
                end
                if (stalled && d_valid_o && d_pkg_o !== held_pkg) begin
                    mon_errors++;
                    $display("d_pkg_o changed while the output was stalled");
                end
                if (d_valid_o && d_ready_i) begin
                    if (exp_q.size() == 0) begin
                        mon_errors++;
                        $display("output transfer with no packet outstanding");
                    end else begin
                        exp  = exp_q.pop_front();
                        name = name_q.pop_front();
                        mon_errors += compare_pkt(name, exp, d_pkg_o);
                        received++;
                    end
                end
            end
            stalled  = !reset_i && d_valid_o && !d_ready_i;
            held_pkg = d_pkg_o;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout, errors %0d, packets sent %0d, received %0d",
                 errors + mon_errors, sent, received);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        f_d_pkg_t    pkt;
        op_kind_e    k0;
        op_kind_e    k1;
        int          drain;
        reset_i   = 1'b1;
        f_valid_i = 1'b0;
        f_pkg_i   = '0;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            errors += check_idle("reset");
        end
        reset_i = 1'b0;
        @(posedge clk);
        #1;
        errors += check_idle("reset");   // first cycle out of reset
        ready_on = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            heavy_stall = (t == NUM_TESTS - 1);
            for (int n = 0; n < NUM_PER_TEST; n++) begin
                r = $random(seed);
                if (r[2:0] == 3'd0) begin   // idle gap
                    f_valid_i = 1'b0;
                    @(posedge clk);
                    #1;
                end
                k0            = pick_kind(t, $random(seed));
                k1            = pick_kind(t, $random(seed));
                pkt.insts[0]  = encode_inst(k0, $random(seed));
                pkt.insts[1]  = encode_inst(k1, $random(seed));
                r             = $random(seed);
                pkt.mask      = (t >= 3) ? r[1:0] : 2'b11;
                r             = $random(seed);
                pkt.pc[0]     = r & 32'hffff_fffc;
                pkt.pc[1]     = pkt.pc[0] + 32'd4;
                exp_q.push_back(expect_pkt(pkt, k0, k1));
                name_q.push_back(test_names[t]);
                send_pkt(pkt);
            end
        end
        f_valid_i = 1'b0;
        f_pkg_i   = '0;

        drain = 0;
        while (received != sent && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            drain++;
        end
        repeat (10) @(posedge clk);   // catch any extra output
        #1;
        if (received != sent) begin
            errors++;
            $display("packet count mismatch, %0d sent and %0d received", sent, received);
        end

        $display("errors %0d, packets sent %0d, received %0d",
                 errors + mon_errors, sent, received);
        if (errors + mon_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+tb
src/decode_pkg.sv
src/basic_decoder.sv
src/imm_extract.sv
src/decoder.sv
src/decode_fifo.sv
src/decode_top.sv
tb/tb_decode_top.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_decode_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
BIN        ?= sim_$(TOP)
PASS_MSG   := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(BIN)
	@out="$$(./$(OBJ_DIR)/$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
